// File: include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Depth of the unified RAM in 32-bit words
`define RAM_WORDS 256

// Cycles from an accepted request to its hit pulse, at least 1
`define RAM_LATENCY 2

// Byte address of the first instruction fetch
`define RESET_PC 32'h0000_0000

`endif

// File: hdl/cpu_types_pkg.sv
package cpu_types_pkg;

   typedef logic [31:0] word_t;

   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_BEQ   = 6'h04,
      OP_ADDIU = 6'h09,
      OP_LUI   = 6'h0F,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2B,
      OP_HALT  = 6'h3F
   } opcode_t;

   typedef enum logic [5:0] {
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_SLT  = 6'h2A
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT,
      ALU_LUI
   } alu_op_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Memory port
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef struct packed {
      logic  ren;
      logic  wen;
      word_t addr;
      word_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic  hit;
      word_t rdata;
   } mem_rsp_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stage payloads, all zeros is a bubble
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef struct packed {
      word_t npc;
      word_t instr;
   } if_id_t;

   typedef struct packed {
      logic        regwrite;
      logic        memtoreg;
      logic        dmem_ren;
      logic        dmem_wen;
      logic        branch;
      logic        halt;
      alu_op_t     alu_op;
      logic        use_imm;
      logic [4:0]  dest;
      word_t       rdat1;
      word_t       rdat2;
      word_t       imm;
      word_t       npc;
   } id_ex_t;

   typedef struct packed {
      logic        regwrite;
      logic        memtoreg;
      logic        dmem_ren;
      logic        dmem_wen;
      logic        branch;
      logic        halt;
      word_t       alu_result;
      logic        zero;
      word_t       store_data;
      logic [4:0]  dest;
      word_t       branch_target;
   } ex_mem_t;

   typedef struct packed {
      logic        regwrite;
      logic        memtoreg;
      logic        halt;
      logic [4:0]  dest;
      word_t       alu_result;
      word_t       load_data;
   } mem_wb_t;

endpackage

// File: hdl/pipe_latch.sv
`timescale 1ns/1ps

module pipe_latch #(
   parameter type payload_t = logic
) (
   input  logic     CLK,
   input  logic     nRST,
   input  logic     en,
   input  logic     flush,
   input  payload_t d,
   output payload_t q
);

   // A flushed stage becomes a bubble even when the pipeline advances
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         q <= '0;
      end else if (flush) begin
         q <= '0;
      end else if (en) begin
         q <= d;
      end
   end

endmodule

// File: hdl/unified_ram.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module unified_ram (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::mem_req_t req,
   output cpu_types_pkg::mem_rsp_t rsp,
   output logic                    busy
);

   localparam int ADDR_W = $clog2(`RAM_WORDS);
   localparam int LAT    = `RAM_LATENCY;

   cpu_types_pkg::word_t mem [`RAM_WORDS] = '{default: '0};

   logic [ADDR_W-1:0]    cap_addr;
   logic                 cap_wen;
   cpu_types_pkg::word_t cap_wdata;
   logic [LAT-1:0]       stage;
   logic                 accept;

   assign accept = (req.ren | req.wen) & ~busy;
   assign busy   = |stage;

   // One valid bit walks through the stages, the last one is the hit
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         stage <= '0;
      end else begin
         stage <= (stage << 1) | LAT'(accept);
      end
   end

   always_ff @(posedge CLK) begin
      if (accept) begin
         cap_addr  <= req.addr[ADDR_W+1:2];
         cap_wen   <= req.wen;
         cap_wdata <= req.wdata;
      end
      if (stage[LAT-1] && cap_wen) begin
         mem[cap_addr] <= cap_wdata;
      end
   end

   assign rsp.hit   = stage[LAT-1];
   assign rsp.rdata = mem[cap_addr];

endmodule

// File: hdl/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::mem_req_t host_req,
   output cpu_types_pkg::mem_rsp_t host_rsp,
   input  cpu_types_pkg::mem_req_t dreq,
   output cpu_types_pkg::mem_rsp_t drsp,
   input  cpu_types_pkg::mem_req_t ireq,
   output cpu_types_pkg::mem_rsp_t irsp,
   output cpu_types_pkg::mem_req_t ram_req,
   input  cpu_types_pkg::mem_rsp_t ram_rsp,
   input  logic                    ram_busy
);

   typedef enum logic [1:0] {
      OWN_NONE,
      OWN_HOST,
      OWN_DATA,
      OWN_INST
   } owner_t;

   owner_t owner;
   owner_t pick;
   logic   grant;

   // Host first, then data, then instruction fetch
   always_comb begin
      pick = OWN_NONE;
      if (host_req.ren | host_req.wen) begin
         pick = OWN_HOST;
      end else if (dreq.ren | dreq.wen) begin
         pick = OWN_DATA;
      end else if (ireq.ren | ireq.wen) begin
         pick = OWN_INST;
      end
   end

   assign grant = (owner == OWN_NONE) & ~ram_busy;

   // The RAM captures the request in the grant cycle only
   always_comb begin
      ram_req = '0;
      if (grant) begin
         case (pick)
            OWN_HOST: ram_req = host_req;
            OWN_DATA: ram_req = dreq;
            OWN_INST: ram_req = ireq;
            default:  ram_req = '0;
         endcase
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         owner <= OWN_NONE;
      end else if (ram_rsp.hit) begin
         owner <= OWN_NONE;
      end else if (grant) begin
         owner <= pick;
      end
   end

   always_comb begin
      host_rsp = '0;
      drsp     = '0;
      irsp     = '0;
      case (owner)
         OWN_HOST: host_rsp = ram_rsp;
         OWN_DATA: drsp     = ram_rsp;
         OWN_INST: irsp     = ram_rsp;
         default:  host_rsp = '0;
      endcase
   end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic                 wen,
   input  logic [4:0]           wsel,
   input  cpu_types_pkg::word_t wdat,
   input  logic [4:0]           rsel1,
   input  logic [4:0]           rsel2,
   output cpu_types_pkg::word_t rdat1,
   output cpu_types_pkg::word_t rdat2
);

   cpu_types_pkg::word_t regs [32];

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && wsel != 5'd0) begin
         regs[wsel] <= wdat;
      end
   end

   // The value being written is visible in the same cycle
   assign rdat1 = (rsel1 == 5'd0) ? '0 :
                  (wen && wsel == rsel1) ? wdat : regs[rsel1];
   assign rdat2 = (rsel2 == 5'd0) ? '0 :
                  (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

// File: hdl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
   input  cpu_types_pkg::word_t  instr,
   input  cpu_types_pkg::word_t  npc,
   input  cpu_types_pkg::word_t  rdat1,
   input  cpu_types_pkg::word_t  rdat2,
   output logic [4:0]            rsel1,
   output logic [4:0]            rsel2,
   output cpu_types_pkg::id_ex_t payload
);

   cpu_types_pkg::opcode_t opcode;
   cpu_types_pkg::funct_t  funct;
   logic                   legal;

   assign opcode = cpu_types_pkg::opcode_t'(instr[31:26]);
   assign funct  = cpu_types_pkg::funct_t'(instr[5:0]);
   assign rsel1  = instr[25:21];
   assign rsel2  = instr[20:16];

   always_comb begin
      payload = '0;
      legal   = 1'b1;
      case (opcode)
         cpu_types_pkg::OP_RTYPE: begin
            payload.regwrite = 1'b1;
            payload.dest     = instr[15:11];
            case (funct)
               cpu_types_pkg::FN_ADDU: payload.alu_op = cpu_types_pkg::ALU_ADD;
               cpu_types_pkg::FN_SUBU: payload.alu_op = cpu_types_pkg::ALU_SUB;
               cpu_types_pkg::FN_AND:  payload.alu_op = cpu_types_pkg::ALU_AND;
               cpu_types_pkg::FN_OR:   payload.alu_op = cpu_types_pkg::ALU_OR;
               cpu_types_pkg::FN_SLT:  payload.alu_op = cpu_types_pkg::ALU_SLT;
               default:                legal = 1'b0;
            endcase
         end
         cpu_types_pkg::OP_ADDIU: begin
            payload.regwrite = 1'b1;
            payload.use_imm  = 1'b1;
            payload.dest     = instr[20:16];
         end
         cpu_types_pkg::OP_LUI: begin
            payload.regwrite = 1'b1;
            payload.use_imm  = 1'b1;
            payload.alu_op   = cpu_types_pkg::ALU_LUI;
            payload.dest     = instr[20:16];
         end
         cpu_types_pkg::OP_LW: begin
            payload.regwrite = 1'b1;
            payload.memtoreg = 1'b1;
            payload.dmem_ren = 1'b1;
            payload.use_imm  = 1'b1;
            payload.dest     = instr[20:16];
         end
         cpu_types_pkg::OP_SW: begin
            payload.dmem_wen = 1'b1;
            payload.use_imm  = 1'b1;
         end
         cpu_types_pkg::OP_BEQ: begin
            payload.branch = 1'b1;
            payload.alu_op = cpu_types_pkg::ALU_SUB;
         end
         cpu_types_pkg::OP_HALT: payload.halt = 1'b1;
         default: legal = 1'b0;
      endcase

      // Anything not recognised leaves the stage as a bubble
      if (legal) begin
         payload.rdat1 = rdat1;
         payload.rdat2 = rdat2;
         payload.npc   = npc;
         payload.imm   = (opcode == cpu_types_pkg::OP_LUI) ? {instr[15:0], 16'h0000} :
                         {{16{instr[15]}}, instr[15:0]};
      end else begin
         payload = '0;
      end
   end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
   input  cpu_types_pkg::alu_op_t op,
   input  cpu_types_pkg::word_t   a,
   input  cpu_types_pkg::word_t   b,
   output cpu_types_pkg::word_t   result,
   output logic                   zero
);

   always_comb begin
      case (op)
         cpu_types_pkg::ALU_ADD: result = a + b;
         cpu_types_pkg::ALU_SUB: result = a - b;
         cpu_types_pkg::ALU_AND: result = a & b;
         cpu_types_pkg::ALU_OR:  result = a | b;
         cpu_types_pkg::ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         // Decode has already moved the immediate into the upper half
         cpu_types_pkg::ALU_LUI: result = b;
         default:                result = '0;
      endcase
   end

   // BEQ subtracts its operands and branches on a zero result
   assign zero = (result == '0);

endmodule

// File: hdl/pipeline_core.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module pipeline_core (
   input  logic                    CLK,
   input  logic                    nRST,
   input  logic                    run,
   output cpu_types_pkg::mem_req_t ireq,
   input  cpu_types_pkg::mem_rsp_t irsp,
   output cpu_types_pkg::mem_req_t dreq,
   input  cpu_types_pkg::mem_rsp_t drsp,
   output logic                    halt
);

   cpu_types_pkg::word_t    pc;
   cpu_types_pkg::word_t    fb_instr;
   logic                    fb_valid;
   logic                    halt_r;
   logic                    stop;
   logic                    mem_needs;
   logic                    adv;
   logic                    taken;
   logic                    flush;
   cpu_types_pkg::if_id_t   if_id_d, if_id_q;
   cpu_types_pkg::id_ex_t   id_ex_d, id_ex_q;
   cpu_types_pkg::ex_mem_t  ex_mem_d, ex_mem_q;
   cpu_types_pkg::mem_wb_t  mem_wb_d, mem_wb_q;
   logic [4:0]              rsel1, rsel2;
   cpu_types_pkg::word_t    rdat1, rdat2;
   cpu_types_pkg::word_t    alu_b, alu_result, wdat;
   logic                    alu_zero;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stall, advance and branch redirect
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign stop      = halt_r | mem_wb_q.halt;
   assign mem_needs = ex_mem_q.dmem_ren | ex_mem_q.dmem_wen;
   assign adv       = fb_valid & (~mem_needs | drsp.hit);
   assign taken     = ex_mem_q.branch & ex_mem_q.zero;
   assign flush     = adv & taken;

   // Fetch only with an empty buffer, so no fetch is in flight during a stall
   assign ireq.ren   = run & ~stop & ~fb_valid;
   assign ireq.wen   = 1'b0;
   assign ireq.addr  = pc;
   assign ireq.wdata = '0;

   // Data access waits for the fetch buffer so its hit always advances
   assign dreq.ren   = ex_mem_q.dmem_ren & fb_valid;
   assign dreq.wen   = ex_mem_q.dmem_wen & fb_valid;
   assign dreq.addr  = ex_mem_q.alu_result;
   assign dreq.wdata = ex_mem_q.store_data;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         pc       <= `RESET_PC;
         fb_valid <= 1'b0;
         halt_r   <= 1'b0;
      end else begin
         halt_r <= halt_r | mem_wb_q.halt;
         if (adv) begin
            pc       <= taken ? ex_mem_q.branch_target : pc + 32'd4;
            fb_valid <= 1'b0;
         end else if (irsp.hit && !stop) begin
            fb_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (irsp.hit) begin
         fb_instr <= irsp.rdata;
      end
   end

   assign halt = halt_r;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Stages
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign if_id_d.npc   = pc + 32'd4;
   assign if_id_d.instr = fb_instr;

   pipe_latch #(.payload_t(cpu_types_pkg::if_id_t)) if_id_latch (
      .CLK, .nRST, .en(adv), .flush(flush), .d(if_id_d), .q(if_id_q)
   );

   decode_unit decoder (
      .instr(if_id_q.instr), .npc(if_id_q.npc), .rdat1(rdat1), .rdat2(rdat2),
      .rsel1(rsel1), .rsel2(rsel2), .payload(id_ex_d)
   );

   register_file regs (
      .CLK, .nRST, .wen(mem_wb_q.regwrite), .wsel(mem_wb_q.dest), .wdat(wdat),
      .rsel1(rsel1), .rsel2(rsel2), .rdat1(rdat1), .rdat2(rdat2)
   );

   pipe_latch #(.payload_t(cpu_types_pkg::id_ex_t)) id_ex_latch (
      .CLK, .nRST, .en(adv), .flush(flush), .d(id_ex_d), .q(id_ex_q)
   );

   assign alu_b = id_ex_q.use_imm ? id_ex_q.imm : id_ex_q.rdat2;

   alu exec_alu (
      .op(id_ex_q.alu_op), .a(id_ex_q.rdat1), .b(alu_b), .result(alu_result), .zero(alu_zero)
   );

   assign ex_mem_d.regwrite      = id_ex_q.regwrite;
   assign ex_mem_d.memtoreg      = id_ex_q.memtoreg;
   assign ex_mem_d.dmem_ren      = id_ex_q.dmem_ren;
   assign ex_mem_d.dmem_wen      = id_ex_q.dmem_wen;
   assign ex_mem_d.branch        = id_ex_q.branch;
   assign ex_mem_d.halt          = id_ex_q.halt;
   assign ex_mem_d.alu_result    = alu_result;
   assign ex_mem_d.zero          = alu_zero;
   assign ex_mem_d.store_data    = id_ex_q.rdat2;
   assign ex_mem_d.dest          = id_ex_q.dest;
   assign ex_mem_d.branch_target = id_ex_q.npc + (id_ex_q.imm << 2);

   pipe_latch #(.payload_t(cpu_types_pkg::ex_mem_t)) ex_mem_latch (
      .CLK, .nRST, .en(adv), .flush(flush), .d(ex_mem_d), .q(ex_mem_q)
   );

   assign mem_wb_d.regwrite   = ex_mem_q.regwrite;
   assign mem_wb_d.memtoreg   = ex_mem_q.memtoreg;
   assign mem_wb_d.halt       = ex_mem_q.halt;
   assign mem_wb_d.dest       = ex_mem_q.dest;
   assign mem_wb_d.alu_result = ex_mem_q.alu_result;
   assign mem_wb_d.load_data  = drsp.rdata;

   // The branch itself retires, so this stage is never flushed
   pipe_latch #(.payload_t(cpu_types_pkg::mem_wb_t)) mem_wb_latch (
      .CLK, .nRST, .en(adv), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
   );

   assign wdat = mem_wb_q.memtoreg ? mem_wb_q.load_data : mem_wb_q.alu_result;

endmodule

// File: hdl/pipeline_cpu.sv
`timescale 1ns/1ps

module pipeline_cpu (
   input  logic                    CLK,
   input  logic                    nRST,
   input  logic                    run,
   input  cpu_types_pkg::mem_req_t host_req,
   output cpu_types_pkg::mem_rsp_t host_rsp,
   output logic                    halt
);

   cpu_types_pkg::mem_req_t ireq;
   cpu_types_pkg::mem_rsp_t irsp;
   cpu_types_pkg::mem_req_t dreq;
   cpu_types_pkg::mem_rsp_t drsp;
   cpu_types_pkg::mem_req_t ram_req;
   cpu_types_pkg::mem_rsp_t ram_rsp;
   logic                    ram_busy;

   pipeline_core core (
      .CLK, .nRST, .run,
      .ireq(ireq), .irsp(irsp),
      .dreq(dreq), .drsp(drsp),
      .halt(halt)
   );

   memory_arbiter arbiter (
      .CLK, .nRST,
      .host_req(host_req), .host_rsp(host_rsp),
      .dreq(dreq), .drsp(drsp),
      .ireq(ireq), .irsp(irsp),
      .ram_req(ram_req), .ram_rsp(ram_rsp), .ram_busy(ram_busy)
   );

   unified_ram ram (
      .CLK, .nRST,
      .req(ram_req),
      .rsp(ram_rsp),
      .busy(ram_busy)
   );

endmodule

// File: verif/pipeline_cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module pipeline_cpu_tb;

   localparam int HOST_TIMEOUT = 40;
   localparam int HALT_TIMEOUT = 4000;
   localparam cpu_types_pkg::word_t DATA_BASE = 32'h0000_0200;
   localparam cpu_types_pkg::word_t NOP       = 32'h0000_0000;
   localparam cpu_types_pkg::word_t HALT_WORD = {cpu_types_pkg::OP_HALT, 26'd0};

   logic                    CLK;
   logic                    nRST;
   logic                    run;
   cpu_types_pkg::mem_req_t host_req;
   cpu_types_pkg::mem_rsp_t host_rsp;
   logic                    halt;

   cpu_types_pkg::word_t    prog [$];

   pipeline_cpu UUT (
      .CLK, .nRST, .run, .host_req, .host_rsp, .halt
   );

   always #50 CLK = ~CLK;

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("** FAIL **");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input cpu_types_pkg::word_t expected,
                             input cpu_types_pkg::word_t actual);
      assert (actual === expected)
         else stop_with_failure($sformatf("Fail %s expected %h actual %h",
                                          name, expected, actual));
   endtask

   // Once halted the core stays halted until the next reset
   assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
      else stop_with_failure("halt fell again without a reset");

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Instruction words and fill pattern
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic cpu_types_pkg::word_t rtype(input cpu_types_pkg::funct_t fn,
                                                  input logic [4:0] rd,
                                                  input logic [4:0] rs,
                                                  input logic [4:0] rt);
      return {6'h00, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic cpu_types_pkg::word_t itype(input cpu_types_pkg::opcode_t op,
                                                  input logic [4:0] rt,
                                                  input logic [4:0] rs,
                                                  input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic cpu_types_pkg::word_t fill_pattern(input cpu_types_pkg::word_t addr);
      return {addr[15:0], addr[31:16]} ^ ~addr ^ 32'h3C5A_96E1;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Host port and run control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic host_access(input logic is_write, input cpu_types_pkg::word_t addr,
                              input cpu_types_pkg::word_t wdata,
                              output cpu_types_pkg::word_t rdata);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      rdata  = '0;
      @(posedge CLK);
      #1;
      host_req.ren   = ~is_write;
      host_req.wen   = is_write;
      host_req.addr  = addr;
      host_req.wdata = wdata;
      while (!seen && cycles < HOST_TIMEOUT) begin
         @(negedge CLK);
         if (host_rsp.hit) begin
            seen  = 1'b1;
            rdata = host_rsp.rdata;
         end
         cycles++;
      end
      // The request is dropped in the cycle after the hit
      @(posedge CLK);
      #1;
      host_req = '0;
      if (!seen) begin
         stop_with_failure($sformatf("host access to %h never got its hit", addr));
      end
   endtask

   task automatic host_write(input cpu_types_pkg::word_t addr, input cpu_types_pkg::word_t data);
      cpu_types_pkg::word_t unused;
      host_access(1'b1, addr, data, unused);
   endtask

   task automatic host_read(input cpu_types_pkg::word_t addr, output cpu_types_pkg::word_t data);
      host_access(1'b0, addr, '0, data);
   endtask

   task automatic preload_fill(input cpu_types_pkg::word_t base, input int words);
      for (int k = 0; k < words; k++) begin
         host_write(base + 32'(4 * k), fill_pattern(base + 32'(4 * k)));
      end
   endtask

   task automatic load_program();
      foreach (prog[i]) begin
         host_write(`RESET_PC + 32'(4 * i), prog[i]);
      end
      prog.delete();
   endtask

   task automatic apply_reset();
      @(posedge CLK);
      #1;
      nRST = 1'b0;
      run  = 1'b0;
      repeat (2) @(posedge CLK);
      #1;
      nRST = 1'b1;
   endtask

   task automatic start_program();
      apply_reset();
      repeat (2) begin
         @(negedge CLK);
         check_word("idle halt", 32'd0, 32'(halt));
         check_word("idle host hit", 32'd0, 32'(host_rsp.hit));
      end
      @(posedge CLK);
      #1;
      run = 1'b1;
   endtask

   task automatic wait_for_halt();
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < HALT_TIMEOUT) begin
         @(negedge CLK);
         seen = halt;
         cycles++;
      end
      if (!seen) begin
         stop_with_failure("the core never raised halt");
      end
      @(posedge CLK);
      #1;
      run = 1'b0;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic reset_test();
      apply_reset();
      repeat (4) begin
         @(negedge CLK);
         check_word("reset halt", 32'd0, 32'(halt));
         check_word("reset host hit", 32'd0, 32'(host_rsp.hit));
      end
   endtask

   task automatic arithmetic_test();
      logic [15:0]          imm1;
      logic [15:0]          imm2;
      logic [15:0]          upper;
      cpu_types_pkg::word_t r [1:10];
      cpu_types_pkg::word_t got;
      imm1  = 16'($urandom_range(16'h7FFF, 1));
      imm2  = 16'h8000 | 16'($urandom);
      upper = 16'h8000 | 16'($urandom);
      r[1]  = {16'h0000, imm1};
      r[2]  = {{16{imm2[15]}}, imm2};
      r[3]  = {upper, 16'h0000};
      r[4]  = r[3] | r[1];
      r[5]  = r[1] + r[2];
      r[6]  = r[1] - r[2];
      r[7]  = r[4] & r[2];
      r[8]  = ($signed(r[2]) < $signed(r[1])) ? 32'd1 : 32'd0;
      r[9]  = ($signed(r[1]) < $signed(r[2])) ? 32'd1 : 32'd0;
      r[10] = ($signed(r[3]) < $signed(r[2])) ? 32'd1 : 32'd0;
      prog.push_back(itype(cpu_types_pkg::OP_ADDIU, 5'd1, 5'd0, imm1));
      prog.push_back(itype(cpu_types_pkg::OP_ADDIU, 5'd2, 5'd0, imm2));
      prog.push_back(itype(cpu_types_pkg::OP_LUI, 5'd3, 5'd0, upper));
      prog.push_back(NOP);
      prog.push_back(NOP);
      prog.push_back(rtype(cpu_types_pkg::FN_OR, 5'd4, 5'd3, 5'd1));
      prog.push_back(rtype(cpu_types_pkg::FN_ADDU, 5'd5, 5'd1, 5'd2));
      prog.push_back(rtype(cpu_types_pkg::FN_SUBU, 5'd6, 5'd1, 5'd2));
      prog.push_back(rtype(cpu_types_pkg::FN_AND, 5'd7, 5'd4, 5'd2));
      prog.push_back(rtype(cpu_types_pkg::FN_SLT, 5'd8, 5'd2, 5'd1));
      prog.push_back(rtype(cpu_types_pkg::FN_SLT, 5'd9, 5'd1, 5'd2));
      prog.push_back(rtype(cpu_types_pkg::FN_SLT, 5'd10, 5'd3, 5'd2));
      for (int k = 1; k <= 10; k++) begin
         prog.push_back(itype(cpu_types_pkg::OP_SW, 5'(k), 5'd0, 16'(DATA_BASE + 4 * (k - 1))));
      end
      prog.push_back(HALT_WORD);
      preload_fill(DATA_BASE, 10);
      load_program();
      start_program();
      wait_for_halt();
      for (int k = 1; k <= 10; k++) begin
         host_read(DATA_BASE + 32'(4 * (k - 1)), got);
         check_word($sformatf("arithmetic r%0d", k), r[k], got);
      end
   endtask

   task automatic load_store_test();
      cpu_types_pkg::word_t base;
      cpu_types_pkg::word_t w [4];
      cpu_types_pkg::word_t sum;
      cpu_types_pkg::word_t got;
      base = DATA_BASE + 32'h40;
      sum  = '0;
      for (int k = 0; k < 4; k++) begin
         w[k] = $urandom;
         sum  = sum + w[k];
         host_write(base + 32'(4 * k), w[k]);
      end
      preload_fill(base + 32'd16, 1);
      for (int k = 0; k < 4; k++) begin
         prog.push_back(itype(cpu_types_pkg::OP_LW, 5'(k + 1), 5'd0, 16'(base + 4 * k)));
      end
      prog.push_back(rtype(cpu_types_pkg::FN_ADDU, 5'd5, 5'd1, 5'd2));
      prog.push_back(NOP);
      prog.push_back(NOP);
      prog.push_back(rtype(cpu_types_pkg::FN_ADDU, 5'd6, 5'd5, 5'd3));
      prog.push_back(NOP);
      prog.push_back(NOP);
      prog.push_back(rtype(cpu_types_pkg::FN_ADDU, 5'd7, 5'd6, 5'd4));
      prog.push_back(NOP);
      prog.push_back(NOP);
      prog.push_back(itype(cpu_types_pkg::OP_SW, 5'd7, 5'd0, 16'(base + 16)));
      prog.push_back(HALT_WORD);
      load_program();
      start_program();
      wait_for_halt();
      host_read(base + 32'd16, got);
      check_word("load sum", sum, got);
   endtask

   task automatic branch_test();
      cpu_types_pkg::word_t base;
      cpu_types_pkg::word_t mark;
      cpu_types_pkg::word_t expected;
      cpu_types_pkg::word_t got;
      base = DATA_BASE + 32'h80;
      mark = {16'h0000, 16'($urandom_range(16'h7FFF, 1))};
      preload_fill(base, 7);
      prog.push_back(itype(cpu_types_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd5));
      prog.push_back(itype(cpu_types_pkg::OP_ADDIU, 5'd2, 5'd0, 16'd5));
      prog.push_back(itype(cpu_types_pkg::OP_ADDIU, 5'd3, 5'd0, 16'd7));
      prog.push_back(itype(cpu_types_pkg::OP_ADDIU, 5'd4, 5'd0, mark[15:0]));
      prog.push_back(NOP);
      prog.push_back(NOP);
      // 5 against 7 falls through to the first three markers
      prog.push_back(itype(cpu_types_pkg::OP_BEQ, 5'd3, 5'd1, 16'd3));
      for (int k = 0; k < 3; k++) begin
         prog.push_back(itype(cpu_types_pkg::OP_SW, 5'd4, 5'd0, 16'(base + 4 * k)));
      end
      // Target is next PC plus three words, just past the second three markers
      prog.push_back(itype(cpu_types_pkg::OP_BEQ, 5'd2, 5'd1, 16'd3));
      for (int k = 3; k < 6; k++) begin
         prog.push_back(itype(cpu_types_pkg::OP_SW, 5'd4, 5'd0, 16'(base + 4 * k)));
      end
      prog.push_back(itype(cpu_types_pkg::OP_SW, 5'd3, 5'd0, 16'(base + 24)));
      prog.push_back(HALT_WORD);
      load_program();
      start_program();
      wait_for_halt();
      for (int k = 0; k < 7; k++) begin
         if (k < 3) begin
            expected = mark;
         end else if (k < 6) begin
            expected = fill_pattern(base + 32'(4 * k));
         end else begin
            expected = 32'd7;
         end
         host_read(base + 32'(4 * k), got);
         check_word($sformatf("branch word %0d", k), expected, got);
      end
   endtask

   task automatic halt_test();
      cpu_types_pkg::word_t base;
      cpu_types_pkg::word_t value;
      cpu_types_pkg::word_t got;
      base  = DATA_BASE + 32'hC0;
      value = {16'h0000, 16'($urandom_range(16'h7FFF, 1))};
      preload_fill(base, 3);
      prog.push_back(itype(cpu_types_pkg::OP_ADDIU, 5'd1, 5'd0, value[15:0]));
      prog.push_back(NOP);
      prog.push_back(NOP);
      prog.push_back(itype(cpu_types_pkg::OP_SW, 5'd1, 5'd0, 16'(base)));
      prog.push_back(HALT_WORD);
      prog.push_back(itype(cpu_types_pkg::OP_SW, 5'd1, 5'd0, 16'(base + 4)));
      prog.push_back(itype(cpu_types_pkg::OP_SW, 5'd1, 5'd0, 16'(base + 8)));
      load_program();
      start_program();
      wait_for_halt();
      repeat (5) @(posedge CLK);
      check_word("halt held", 32'd1, 32'(halt));
      host_read(base, got);
      check_word("halt store before", value, got);
      host_read(base + 32'd4, got);
      check_word("halt store after", fill_pattern(base + 32'd4), got);
      host_read(base + 32'd8, got);
      check_word("halt store after", fill_pattern(base + 32'd8), got);
   endtask

   task automatic arbitration_test();
      cpu_types_pkg::word_t base;
      cpu_types_pkg::word_t w [3];
      cpu_types_pkg::word_t probe;
      cpu_types_pkg::word_t got;
      int                   count;
      base  = DATA_BASE + 32'h100;
      count = 6;
      probe = $urandom;
      for (int k = 0; k < 3; k++) begin
         w[k] = $urandom;
         host_write(base + 32'(4 * k), w[k]);
      end
      preload_fill(base + 32'd16, 2);
      host_write(base + 32'd32, probe);
      prog.push_back(itype(cpu_types_pkg::OP_ADDIU, 5'd1, 5'd0, 16'(count)));
      prog.push_back(NOP);
      prog.push_back(NOP);
      prog.push_back(itype(cpu_types_pkg::OP_LW, 5'd3, 5'd0, 16'(base)));
      prog.push_back(itype(cpu_types_pkg::OP_LW, 5'd4, 5'd0, 16'(base + 4)));
      prog.push_back(itype(cpu_types_pkg::OP_ADDIU, 5'd1, 5'd1, 16'hFFFF));
      prog.push_back(rtype(cpu_types_pkg::FN_ADDU, 5'd2, 5'd2, 5'd3));
      prog.push_back(itype(cpu_types_pkg::OP_LW, 5'd7, 5'd0, 16'(base + 8)));
      prog.push_back(NOP);
      prog.push_back(rtype(cpu_types_pkg::FN_ADDU, 5'd2, 5'd2, 5'd4));
      prog.push_back(itype(cpu_types_pkg::OP_BEQ, 5'd0, 5'd1, 16'd1));
      // Back to the first load, nine words before the next PC
      prog.push_back(itype(cpu_types_pkg::OP_BEQ, 5'd0, 5'd0, 16'hFFF7));
      prog.push_back(itype(cpu_types_pkg::OP_SW, 5'd2, 5'd0, 16'(base + 16)));
      prog.push_back(itype(cpu_types_pkg::OP_SW, 5'd7, 5'd0, 16'(base + 20)));
      prog.push_back(HALT_WORD);
      load_program();
      start_program();
      repeat ($urandom_range(12, 3)) @(posedge CLK);
      host_read(base + 32'd32, got);
      check_word("arbitration probe", probe, got);
      host_read(base, got);
      check_word("arbitration shared word", w[0], got);
      assert (!halt)
         else stop_with_failure("the program halted before the host reads were done");
      wait_for_halt();
      host_read(base + 32'd16, got);
      check_word("arbitration sum", 32'(count) * (w[0] + w[1]), got);
      host_read(base + 32'd20, got);
      check_word("arbitration last load", w[2], got);
   endtask

   initial begin
      int seed;
      seed = 58;
      void'($urandom(seed));
      CLK      = 1'b0;
      nRST     = 1'b0;
      run      = 1'b0;
      host_req = '0;
      reset_test();
      arithmetic_test();
      load_store_test();
      branch_test();
      halt_test();
      arbitration_test();
      $display("** PASS **");
      $finish;
   end

endmodule

// File: files.f
+incdir+include
hdl/cpu_types_pkg.sv
hdl/pipe_latch.sv
hdl/unified_ram.sv
hdl/memory_arbiter.sv
hdl/register_file.sv
hdl/decode_unit.sv
hdl/alu.sv
hdl/pipeline_core.sv
hdl/pipeline_cpu.sv
verif/pipeline_cpu_tb.sv

// File: Makefile
TOP := pipeline_cpu_tb
OBJ := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): files.f $(wildcard hdl/*.sv include/*.svh verif/*.sv)
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -Mdir $(OBJ)

run: $(OBJ)/V$(TOP)
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing -f files.f --top-module pipeline_cpu
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf $(OBJ)
